/* common/pbch_pkg.sv */
`default_nettype none

package pbch_pkg;

    // sample format, real part in the low half and imaginary part in the high half
    localparam int IQ_DW = 32;
    localparam int CELL_ID_DW = 10;
    localparam int IBAR_DW = 3;
    localparam int NUM_IBAR = 8;

    // gold sequence generator
    localparam int LFSR_N = 31;
    localparam int GOLD_NC = 1600;
    localparam int GOLD_STEP_DW = 11;

    // PBCH symbol layout
    localparam int SYMBOL_LEN = 240;
    localparam int SC_IDX_DW = 8;
    localparam int PILOT_SPACING = 4;
    localparam int PILOT_OFS_DW = $clog2(PILOT_SPACING);
    localparam int NUM_PILOTS = 60;
    localparam int PILOT_IDX_DW = 6;

    // two gold bits per pilot pair
    localparam int PILOT_BITS = 2 * NUM_PILOTS;
    localparam int BIT_IDX_DW = 7;

    // correlation sums stay within +-120
    localparam int CORR_DW = 8;
    localparam int METRIC_DW = 7;

    typedef logic [IQ_DW-1:0] sample_t;
    typedef logic signed [CORR_DW-1:0] corr_t;
    typedef logic [PILOT_IDX_DW-1:0] pilot_idx_t;
    typedef logic [IBAR_DW-1:0] ibar_t;
    typedef logic [CELL_ID_DW-1:0] cell_id_t;

endpackage

`default_nettype wire

/* dmrs_gen/gold_seq_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module gold_seq_gen
    import pbch_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     reset_ni,
    input  wire cell_id_t           cell_id_i,
    input  wire                     cell_id_valid_i,
    input  wire                     load_i,
    output logic [NUM_IBAR-1:0]     gold_bits_o,
    output logic [PILOT_OFS_DW-1:0] pilot_offset_o
);

    // x1 is the same for every candidate
    logic [LFSR_N-1:0] x1_q;

    // floor(N/4) + 1
    logic [LFSR_N-1:0] n_quarter;

    assign n_quarter = LFSR_N'(cell_id_i[CELL_ID_DW-1:2]) + 1'b1;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            x1_q           <= LFSR_N'(1);
            pilot_offset_o <= '0;
        end else begin
            if (cell_id_valid_i) begin
                pilot_offset_o <= cell_id_i[PILOT_OFS_DW-1:0];
            end
            if (load_i) begin
                x1_q <= LFSR_N'(1);
            end else begin
                x1_q <= {x1_q[3] ^ x1_q[0], x1_q[LFSR_N-1:1]};
            end
        end
    end

    for (genvar gi = 0; gi < NUM_IBAR; gi++) begin : g_x2
        localparam logic [LFSR_N-1:0] IBAR_P1 = LFSR_N'(gi + 1);

        logic [LFSR_N-1:0] c_init_q;
        logic [LFSR_N-1:0] x2_q;

        // c_init = 2^11 (ibar+1)(floor(N/4)+1) + 2^6 (ibar+1) + N mod 4
        always_ff @(posedge clk_i) begin
            if (cell_id_valid_i) begin
                c_init_q <= ((IBAR_P1 * n_quarter) << 11) + (IBAR_P1 << 6)
                            + LFSR_N'(cell_id_i[1:0]);
            end
        end

        always_ff @(posedge clk_i) begin
            if (!reset_ni) begin
                x2_q <= '0;
            end else if (load_i) begin
                x2_q <= c_init_q;
            end else begin
                x2_q <= {x2_q[3] ^ x2_q[2] ^ x2_q[1] ^ x2_q[0], x2_q[LFSR_N-1:1]};
            end
        end

        assign gold_bits_o[gi] = x1_q[0] ^ x2_q[0];
    end

endmodule

`default_nettype wire

/* dmrs_gen/dmrs_gen_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module dmrs_gen_fsm
    import pbch_pkg::*;
(
    input  wire                   clk_i,
    input  wire                   reset_ni,
    input  wire                   cell_id_valid_i,
    output logic                  lfsr_load_o,
    output logic                  store_en_o,
    output logic [BIT_IDX_DW-1:0] bit_idx_o,
    output logic                  dmrs_ready_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SKIP,
        ST_STORE,
        ST_DONE
    } gen_state_t;

    gen_state_t state_q;

    // shared by the skip and the store phase
    logic [GOLD_STEP_DW-1:0] step_q;

    assign lfsr_load_o = (state_q == ST_LOAD);
    assign store_en_o  = (state_q == ST_STORE);
    assign bit_idx_o   = step_q[BIT_IDX_DW-1:0];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= ST_IDLE;
            step_q       <= '0;
            dmrs_ready_o <= 1'b0;
        end else begin
            // ready follows the done state by one cycle, a new cell id drops it at once
            dmrs_ready_o <= (state_q == ST_DONE) && !cell_id_valid_i;
            if (cell_id_valid_i) begin
                state_q <= ST_LOAD;
                step_q  <= '0;
            end else begin
                case (state_q)
                    ST_LOAD: begin
                        state_q <= ST_SKIP;
                        step_q  <= '0;
                    end
                    ST_SKIP: begin
                        // lfsr output in this cycle is x(step_q)
                        if (step_q == GOLD_STEP_DW'(GOLD_NC - 1)) begin
                            state_q <= ST_STORE;
                            step_q  <= '0;
                        end else begin
                            step_q <= step_q + 1'b1;
                        end
                    end
                    ST_STORE: begin
                        if (step_q == GOLD_STEP_DW'(PILOT_BITS - 1)) begin
                            state_q <= ST_DONE;
                        end else begin
                            step_q <= step_q + 1'b1;
                        end
                    end
                    default: begin
                        state_q <= state_q;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* ibar_detect/sc_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module sc_counter
    import pbch_pkg::*;
(
    input  wire                     clk_i,
    input  wire                     reset_ni,
    input  wire                     clear_i,
    input  wire                     iq_valid_i,
    input  wire [PILOT_OFS_DW-1:0]  pilot_offset_i,
    output logic                    active_o,
    output logic                    pilot_o,
    output pilot_idx_t              pilot_idx_o,
    output logic                    symbol_done_o
);

    logic [SC_IDX_DW-1:0] sc_cnt_q;
    logic [SC_IDX_DW-1:0] sc_rel;
    pilot_idx_t           pilot_cnt_q;
    logic                 sample_en;
    logic                 is_pilot;
    logic                 last_sample;

    assign sample_en   = active_o && iq_valid_i;
    assign sc_rel      = sc_cnt_q - SC_IDX_DW'(pilot_offset_i);
    assign is_pilot    = (sc_rel % PILOT_SPACING) == 0;
    assign last_sample = (sc_cnt_q == SC_IDX_DW'(SYMBOL_LEN - 1));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            active_o      <= 1'b0;
            sc_cnt_q      <= '0;
            pilot_cnt_q   <= '0;
            pilot_idx_o   <= '0;
            pilot_o       <= 1'b0;
            symbol_done_o <= 1'b0;
        end else begin
            // strobes line up with the sample register in the correlator
            pilot_o       <= sample_en && is_pilot && !clear_i;
            symbol_done_o <= sample_en && last_sample && !clear_i;
            if (clear_i) begin
                active_o    <= 1'b1;
                sc_cnt_q    <= '0;
                pilot_cnt_q <= '0;
            end else if (sample_en) begin
                sc_cnt_q <= sc_cnt_q + 1'b1;
                if (is_pilot) begin
                    pilot_idx_o <= pilot_cnt_q;
                    pilot_cnt_q <= pilot_cnt_q + 1'b1;
                end
                if (last_sample) begin
                    active_o <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* ibar_detect/dmrs_correlator.sv */
`timescale 1ns/1ns
`default_nettype none

module dmrs_correlator
    import pbch_pkg::*;
(
    input  wire                    clk_i,
    input  wire                    reset_ni,
    input  wire                    store_en_i,
    input  wire [BIT_IDX_DW-1:0]   bit_idx_i,
    input  wire [NUM_IBAR-1:0]     gold_bits_i,
    input  wire                    clear_i,
    input  wire sample_t           iq_data_i,
    input  wire                    pilot_i,
    input  wire pilot_idx_t        pilot_idx_i,
    input  wire ibar_t             sel_i,
    output logic [METRIC_DW-1:0]   metric_o
);

    // reference pilots, one bit per candidate in each word
    logic [NUM_IBAR-1:0] ref_hi_mem [NUM_PILOTS];
    logic [NUM_IBAR-1:0] ref_lo_mem [NUM_PILOTS];

    sample_t             sample_q;
    logic [NUM_IBAR-1:0] ref_hi;
    logic [NUM_IBAR-1:0] ref_lo;
    logic [1:0]          rx_bits;
    logic [1:0]          rx_bits_rot;
    corr_t               corr_q [NUM_IBAR];
    corr_t               corr_rot_q [NUM_IBAR];
    logic [METRIC_DW-1:0] mag_norm;
    logic [METRIC_DW-1:0] mag_rot;

    // +1 per matching bit, -1 per mismatch
    function automatic corr_t pair_score(input logic [1:0] ref_bits, input logic [1:0] rx);
        corr_t score;
        score = '0;
        score = (ref_bits[1] == rx[1]) ? score + corr_t'(1) : score - corr_t'(1);
        score = (ref_bits[0] == rx[0]) ? score + corr_t'(1) : score - corr_t'(1);
        return score;
    endfunction

    function automatic logic [METRIC_DW-1:0] abs_corr(input corr_t value);
        corr_t mag;
        mag = value[CORR_DW-1] ? -value : value;
        return mag[METRIC_DW-1:0];
    endfunction

    // even bit index is c(2m), odd is c(2m+1)
    always_ff @(posedge clk_i) begin
        if (store_en_i) begin
            if (bit_idx_i[0]) begin
                ref_lo_mem[bit_idx_i[BIT_IDX_DW-1:1]] <= gold_bits_i;
            end else begin
                ref_hi_mem[bit_idx_i[BIT_IDX_DW-1:1]] <= gold_bits_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        sample_q <= iq_data_i;
    end

    assign ref_hi = ref_hi_mem[pilot_idx_i];
    assign ref_lo = ref_lo_mem[pilot_idx_i];

    // hard QPSK decision, plain and turned by 90 degrees
    assign rx_bits     = {sample_q[IQ_DW/2-1], sample_q[IQ_DW-1]};
    assign rx_bits_rot = {~sample_q[IQ_DW-1], sample_q[IQ_DW/2-1]};

    always_ff @(posedge clk_i) begin
        if (!reset_ni || clear_i) begin
            for (int i = 0; i < NUM_IBAR; i++) begin
                corr_q[i]     <= '0;
                corr_rot_q[i] <= '0;
            end
        end else if (pilot_i) begin
            for (int i = 0; i < NUM_IBAR; i++) begin
                corr_q[i]     <= corr_q[i] + pair_score({ref_hi[i], ref_lo[i]}, rx_bits);
                corr_rot_q[i] <= corr_rot_q[i] + pair_score({ref_hi[i], ref_lo[i]}, rx_bits_rot);
            end
        end
    end

    assign mag_norm = abs_corr(corr_q[sel_i]);
    assign mag_rot  = abs_corr(corr_rot_q[sel_i]);
    assign metric_o = (mag_rot > mag_norm) ? mag_rot : mag_norm;

endmodule

`default_nettype wire

/* ibar_detect/ibar_detect_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module ibar_detect_fsm
    import pbch_pkg::*;
(
    input  wire                  clk_i,
    input  wire                  reset_ni,
    input  wire                  pbch_start_i,
    input  wire                  dmrs_ready_i,
    input  wire                  symbol_done_i,
    input  wire [METRIC_DW-1:0]  metric_i,
    output logic                 sc_clear_o,
    output ibar_t                sel_o,
    output ibar_t                ibar_ssb_o,
    output logic                 ibar_valid_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CAPTURE,
        ST_SEARCH,
        ST_REPORT
    } det_state_t;

    det_state_t           state_q;
    logic [METRIC_DW-1:0] best_metric_q;
    ibar_t                best_idx_q;

    // start pulses outside idle or before the pilots exist are dropped
    assign sc_clear_o = (state_q == ST_IDLE) && pbch_start_i && dmrs_ready_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q       <= ST_IDLE;
            sel_o         <= '0;
            best_metric_q <= '0;
            best_idx_q    <= '0;
            ibar_ssb_o    <= '0;
            ibar_valid_o  <= 1'b0;
        end else begin
            ibar_valid_o <= 1'b0;
            if (state_q != ST_IDLE && !dmrs_ready_i) begin
                // pilots are being rebuilt for a new cell
                state_q <= ST_IDLE;
            end else begin
                case (state_q)
                    ST_IDLE: begin
                        if (sc_clear_o) begin
                            state_q <= ST_CAPTURE;
                        end
                    end
                    ST_CAPTURE: begin
                        if (symbol_done_i) begin
                            state_q       <= ST_SEARCH;
                            sel_o         <= '0;
                            best_metric_q <= '0;
                            best_idx_q    <= '0;
                        end
                    end
                    ST_SEARCH: begin
                        // strict compare keeps the lowest ibar on a tie
                        if (metric_i > best_metric_q) begin
                            best_metric_q <= metric_i;
                            best_idx_q    <= sel_o;
                        end
                        if (sel_o == ibar_t'(NUM_IBAR - 1)) begin
                            state_q <= ST_REPORT;
                        end else begin
                            sel_o <= sel_o + 1'b1;
                        end
                    end
                    default: begin
                        ibar_ssb_o   <= best_idx_q;
                        ibar_valid_o <= 1'b1;
                        state_q      <= ST_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/pbch_dmrs_detector.sv */
`timescale 1ns/1ns
`default_nettype none

module pbch_dmrs_detector
    import pbch_pkg::*;
(
    input  wire            clk_i,
    input  wire            reset_ni,
    input  wire cell_id_t  cell_id_i,
    input  wire            cell_id_valid_i,
    input  wire sample_t   iq_data_i,
    input  wire            iq_valid_i,
    input  wire            pbch_start_i,
    output logic           dmrs_ready_o,
    output ibar_t          ibar_ssb_o,
    output logic           ibar_valid_o
);

    logic                    lfsr_load;
    logic                    store_en;
    logic [BIT_IDX_DW-1:0]   bit_idx;
    logic [NUM_IBAR-1:0]     gold_bits;
    logic [PILOT_OFS_DW-1:0] pilot_offset;
    logic                    sc_clear;
    logic                    pilot;
    pilot_idx_t              pilot_idx;
    logic                    symbol_done;
    ibar_t                   sel;
    logic [METRIC_DW-1:0]    metric;

    gold_seq_gen gold_seq_gen_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .cell_id_i      (cell_id_i),
        .cell_id_valid_i(cell_id_valid_i),
        .load_i         (lfsr_load),
        .gold_bits_o    (gold_bits),
        .pilot_offset_o (pilot_offset)
    );

    dmrs_gen_fsm dmrs_gen_fsm_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .cell_id_valid_i(cell_id_valid_i),
        .lfsr_load_o    (lfsr_load),
        .store_en_o     (store_en),
        .bit_idx_o      (bit_idx),
        .dmrs_ready_o   (dmrs_ready_o)
    );

    sc_counter sc_counter_i (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .clear_i       (sc_clear),
        .iq_valid_i    (iq_valid_i),
        .pilot_offset_i(pilot_offset),
        .active_o      (),
        .pilot_o       (pilot),
        .pilot_idx_o   (pilot_idx),
        .symbol_done_o (symbol_done)
    );

    dmrs_correlator dmrs_correlator_i (
        .clk_i      (clk_i),
        .reset_ni   (reset_ni),
        .store_en_i (store_en),
        .bit_idx_i  (bit_idx),
        .gold_bits_i(gold_bits),
        .clear_i    (sc_clear),
        .iq_data_i  (iq_data_i),
        .pilot_i    (pilot),
        .pilot_idx_i(pilot_idx),
        .sel_i      (sel),
        .metric_o   (metric)
    );

    ibar_detect_fsm ibar_detect_fsm_i (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .pbch_start_i (pbch_start_i),
        .dmrs_ready_i (dmrs_ready_o),
        .symbol_done_i(symbol_done),
        .metric_i     (metric),
        .sc_clear_o   (sc_clear),
        .sel_o        (sel),
        .ibar_ssb_o   (ibar_ssb_o),
        .ibar_valid_o (ibar_valid_o)
    );

endmodule

`default_nettype wire

/* tb/pbch_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module pbch_checker
    import pbch_pkg::*;
(
    input wire        clk_i,
    input wire        reset_ni,
    input wire        dmrs_ready_i,
    input wire        ibar_valid_i,
    input wire ibar_t ibar_ssb_i
);

    int assert_errors = 0;

    // the result strobe is a single-cycle pulse
    a_valid_pulse: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_i |=> !ibar_valid_i)
        else begin
            $error("ibar_valid_o stayed high for more than one cycle");
            assert_errors++;
        end

    a_valid_ready: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_i |-> dmrs_ready_i)
        else begin
            $error("ibar_valid_o high while the reference pilots are not ready");
            assert_errors++;
        end

    a_ibar_known: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ibar_valid_i |-> !$isunknown(ibar_ssb_i))
        else begin
            $error("ibar_ssb_o holds unknown bits during ibar_valid_o");
            assert_errors++;
        end

endmodule

`default_nettype wire

/* tb/pbch_monitor.sv */
`timescale 1ns/1ns
`default_nettype none

module pbch_monitor
    import pbch_pkg::*;
(
    input  wire        clk_i,
    input  wire        reset_ni,
    input  wire        cell_id_valid_i,
    input  wire        dmrs_ready_i,
    input  wire        ibar_valid_i,
    input  wire ibar_t ibar_ssb_i,
    input  wire [7:0]  test_id_i,
    input  wire ibar_t exp_ibar_i,
    input  wire        expect_i,
    input  wire        quiet_done_i,
    input  wire [1:0]  timeout_i,
    input  wire        summary_i,
    output int         error_count_o
);

    int   passes;
    int   errors;
    logic reset_checked;
    logic cell_valid_seen;
    logic unexpected_seen;

    assign error_count_o = errors;

    // DUT outputs are sampled on the falling edge
    always @(negedge clk_i) begin
        if (!reset_ni) begin
            passes          = 0;
            errors          = 0;
            reset_checked   = 1'b0;
            cell_valid_seen = 1'b0;
            unexpected_seen = 1'b0;
        end else begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (dmrs_ready_i !== 1'b0 || ibar_valid_i !== 1'b0 ||
                    ibar_ssb_i !== '0) begin
                    $display("ERROR reset: ready/valid/ibar expected 0/0/0 actual %b/%b/%0d",
                             dmrs_ready_i, ibar_valid_i, ibar_ssb_i);
                    errors++;
                end else begin
                    $display("reset: passed, dmrs_ready_o, ibar_valid_o and ibar_ssb_o are low");
                    passes++;
                end
            end
            // ready must be low one cycle after a new cell id
            if (cell_valid_seen && dmrs_ready_i !== 1'b0) begin
                $display("ERROR row%0d: dmrs_ready_o expected 0 actual %b", test_id_i,
                         dmrs_ready_i);
                errors++;
            end
            cell_valid_seen = cell_id_valid_i;
            if (ibar_valid_i === 1'b1) begin
                if (!expect_i) begin
                    $display("unexpected ibar_valid_o pulse while no result was awaited");
                    unexpected_seen = 1'b1;
                    errors++;
                end else if (ibar_ssb_i !== exp_ibar_i) begin
                    $display("ERROR row%0d: ibar_ssb_o expected %0d actual %0d", test_id_i,
                             exp_ibar_i, ibar_ssb_i);
                    errors++;
                end else begin
                    $display("row%0d: passed, ibar_ssb_o = %0d", test_id_i, ibar_ssb_i);
                    passes++;
                end
            end
            if (timeout_i == 2'd1) begin
                $display("row%0d: dmrs_ready_o did not rise within 3000 cycles", test_id_i);
                errors++;
            end
            if (timeout_i == 2'd2) begin
                $display("row%0d: ibar_valid_o did not arrive within 100 cycles", test_id_i);
                errors++;
            end
            if (quiet_done_i) begin
                if (unexpected_seen) begin
                    $display("no_cell: failed, a result appeared before any cell id");
                end else begin
                    $display("no_cell: passed, no result without a cell id");
                    passes++;
                end
            end
            if (summary_i) begin
                $display("summary: %0d passed, %0d errors", passes, errors);
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_pbch_dmrs_detector.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_pbch_dmrs_detector
    import pbch_pkg::*;
();

    logic       clk_i;
    logic       reset_ni;
    cell_id_t   cell_id_i;
    logic       cell_id_valid_i;
    sample_t    iq_data_i;
    logic       iq_valid_i;
    logic       pbch_start_i;
    logic       dmrs_ready_o;
    ibar_t      ibar_ssb_o;
    logic       ibar_valid_o;

    // monitor control
    logic [7:0] test_id;
    ibar_t      exp_ibar;
    logic       expect_result;
    logic       quiet_done;
    logic [1:0] timeout_code;
    logic       summary_req;
    int         error_count;

    integer           seed;
    bit               gold_ref [PILOT_BITS];
    int               fd;
    int               nread;
    int               nfields;
    int               row;
    int               cur_cell;
    int               setup_errors;
    int               f_cell;
    int               f_sent;
    int               f_rot;
    int               f_flip;
    int               f_exp;
    bit               cell_loaded;
    bit               seen;
    logic [8*128-1:0] line;

    pbch_dmrs_detector pbch_dmrs_detector_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .cell_id_i      (cell_id_i),
        .cell_id_valid_i(cell_id_valid_i),
        .iq_data_i      (iq_data_i),
        .iq_valid_i     (iq_valid_i),
        .pbch_start_i   (pbch_start_i),
        .dmrs_ready_o   (dmrs_ready_o),
        .ibar_ssb_o     (ibar_ssb_o),
        .ibar_valid_o   (ibar_valid_o)
    );

    pbch_monitor monitor_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .cell_id_valid_i(cell_id_valid_i),
        .dmrs_ready_i   (dmrs_ready_o),
        .ibar_valid_i   (ibar_valid_o),
        .ibar_ssb_i     (ibar_ssb_o),
        .test_id_i      (test_id),
        .exp_ibar_i     (exp_ibar),
        .expect_i       (expect_result),
        .quiet_done_i   (quiet_done),
        .timeout_i      (timeout_code),
        .summary_i      (summary_req),
        .error_count_o  (error_count)
    );

    bind ibar_detect_fsm pbch_checker pbch_checker_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .dmrs_ready_i(dmrs_ready_i),
        .ibar_valid_i(ibar_valid_o),
        .ibar_ssb_i  (ibar_ssb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // reference pilot bits c(0) .. c(119) for one cell id and ibar
    task automatic make_gold(input int cell_id, input int ibar);
        int c_init;
        bit x1 [GOLD_NC + PILOT_BITS + LFSR_N];
        bit x2 [GOLD_NC + PILOT_BITS + LFSR_N];
        c_init = 2048 * (ibar + 1) * (cell_id / 4 + 1) + 64 * (ibar + 1) + cell_id % 4;
        for (int n = 0; n < LFSR_N; n++) begin
            x1[n] = (n == 0);
            x2[n] = c_init[n];
        end
        for (int n = 0; n < GOLD_NC + PILOT_BITS; n++) begin
            x1[n + 31] = x1[n + 3] ^ x1[n];
            x2[n + 31] = x2[n + 3] ^ x2[n + 2] ^ x2[n + 1] ^ x2[n];
        end
        for (int n = 0; n < PILOT_BITS; n++) begin
            gold_ref[n] = x1[n + GOLD_NC] ^ x2[n + GOLD_NC];
        end
    endtask

    task automatic send_symbol(input int offset, input bit rotate, input int flips);
        int                 m;
        logic [1:0]         pb;
        logic signed [15:0] re;
        logic signed [15:0] im;
        sample_t            smp;
        @(posedge clk_i);
        pbch_start_i <= 1'b1;
        for (int k = 0; k < SYMBOL_LEN; k++) begin
            @(posedge clk_i);
            pbch_start_i <= 1'b0;
            if (k >= offset && (k - offset) % PILOT_SPACING == 0) begin
                m  = (k - offset) / PILOT_SPACING;
                pb = {gold_ref[2 * m], gold_ref[2 * m + 1]};
                // the first pilots carry a wrong first bit
                if (m < flips) begin
                    pb[1] = ~pb[1];
                end
                // bit 0 maps to +1000, bit 1 to -1000
                re = pb[1] ? -16'sd1000 : 16'sd1000;
                im = pb[0] ? -16'sd1000 : 16'sd1000;
                // times j gives real part -im and imaginary part re
                smp = rotate ? {re, -im} : {im, re};
            end else begin
                smp = $random(seed);
            end
            iq_data_i  <= smp;
            iq_valid_i <= 1'b1;
        end
        @(posedge clk_i);
        iq_valid_i <= 1'b0;
    endtask

    task automatic wait_ready(input int limit, output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < limit) begin
            @(negedge clk_i);
            found  = (dmrs_ready_o === 1'b1);
            cycles = cycles + 1;
        end
    endtask

    task automatic wait_result(input int limit, output bit found);
        int cycles;
        found  = 1'b0;
        cycles = 0;
        while (!found && cycles < limit) begin
            @(negedge clk_i);
            found  = (ibar_valid_o === 1'b1);
            cycles = cycles + 1;
        end
    endtask

    task automatic raise_timeout(input logic [1:0] code);
        @(posedge clk_i);
        timeout_code <= code;
        @(posedge clk_i);
        timeout_code <= 2'd0;
    endtask

    task automatic run_row();
        @(posedge clk_i);
        test_id  <= 8'(row);
        exp_ibar <= ibar_t'(f_exp);
        // a new cell id rebuilds the pilots
        if (!cell_loaded || f_cell != cur_cell) begin
            cell_id_i       <= cell_id_t'(f_cell);
            cell_id_valid_i <= 1'b1;
            @(posedge clk_i);
            cell_id_valid_i <= 1'b0;
            wait_ready(3000, seen);
            cell_loaded = seen;
            cur_cell    = f_cell;
            if (!seen) begin
                raise_timeout(2'd1);
            end
        end
        if (cell_loaded) begin
            make_gold(f_cell, f_sent);
            @(posedge clk_i);
            expect_result <= 1'b1;
            send_symbol(f_cell % PILOT_SPACING, f_rot != 0, f_flip);
            wait_result(100, seen);
            @(posedge clk_i);
            expect_result <= 1'b0;
            if (!seen) begin
                raise_timeout(2'd2);
            end
        end
    endtask

    initial begin
        seed            = 32'hfb04a29b;
        reset_ni        = 1'b0;
        cell_id_i       = '0;
        cell_id_valid_i = 1'b0;
        iq_data_i       = '0;
        iq_valid_i      = 1'b0;
        pbch_start_i    = 1'b0;
        test_id         = '0;
        exp_ibar        = '0;
        expect_result   = 1'b0;
        quiet_done      = 1'b0;
        timeout_code    = 2'd0;
        summary_req     = 1'b0;
        row             = 0;
        cur_cell        = -1;
        cell_loaded     = 1'b0;
        setup_errors    = 0;
        repeat (3) @(posedge clk_i);
        reset_ni <= 1'b1;

        // a symbol before any cell id is ignored
        make_gold(0, 0);
        send_symbol(0, 1'b0, 0);
        repeat (400) @(negedge clk_i);
        @(posedge clk_i);
        quiet_done <= 1'b1;
        @(posedge clk_i);
        quiet_done <= 1'b0;

        fd = $fopen("tb/pbch_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/pbch_stim.txt");
            setup_errors++;
        end else begin
            while (!$feof(fd)) begin
                nread   = $fgets(line, fd);
                nfields = 0;
                if (nread > 0) begin
                    nfields = $sscanf(line, "%d %d %d %d %d", f_cell, f_sent, f_rot, f_flip,
                                      f_exp);
                end
                if (nfields == 5) begin
                    row++;
                    run_row();
                end
            end
            $fclose(fd);
            if (row == 0) begin
                $display("no test rows were found in tb/pbch_stim.txt");
                setup_errors++;
            end
        end

        @(posedge clk_i);
        summary_req <= 1'b1;
        @(posedge clk_i);
        summary_req <= 1'b0;
        @(posedge clk_i);
        if (error_count == 0 && setup_errors == 0 &&
            pbch_dmrs_detector_i.ibar_detect_fsm_i.pbch_checker_i.assert_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/pbch_stim.txt */
# cell_id sent_ibar rotated flipped_pilots expected_ibar
# decimal fields, one test per line
0 0 0 0 0
0 5 0 0 5
1 3 0 0 3
1 7 0 0 7
2 1 0 0 1
2 6 0 0 6
3 2 0 0 2
3 4 0 0 4
503 7 0 0 7
503 0 1 0 0
503 4 1 0 4
1007 2 1 0 2
1007 6 0 4 6
1007 1 0 10 1
614 5 1 7 5
614 3 0 10 3
17 0 1 10 0
17 7 0 2 7
1006 5 0 0 5
1006 2 1 10 2
256 1 0 0 1
256 6 1 3 6

/* vlog.f */
common/pbch_pkg.sv
dmrs_gen/gold_seq_gen.sv
dmrs_gen/dmrs_gen_fsm.sv
ibar_detect/sc_counter.sv
ibar_detect/dmrs_correlator.sv
ibar_detect/ibar_detect_fsm.sv
hdl/pbch_dmrs_detector.sv
tb/pbch_checker.sv
tb/pbch_monitor.sv
tb/tb_pbch_dmrs_detector.sv
